//--- rtl/dl_macros.svh
/*
 * Sizes and codes for the ROM download path
 *   shared word RAM and boot-ROM RAM address widths and depths
 *   download index codes, compared on index bits 5..0
 *   word base addresses of the two cartridge regions
 */

`ifndef DL_MACROS_SVH
`define DL_MACROS_SVH

// ==================================================
// Memory sizes
// ==================================================
`define DL_MEM_AW    10
`define DL_MEM_WORDS (1 << `DL_MEM_AW)
`define DL_PIF_AW    10
`define DL_PIF_WORDS (1 << `DL_PIF_AW)

// ==================================================
// Download index codes and cartridge bases
// ==================================================
`define DL_IDX_PIF   6'd0
`define DL_IDX_N64   6'd1
`define DL_IDX_GB    6'd2

// Word addresses in the shared RAM
`define DL_N64_BASE  512
`define DL_GB_BASE   256

`endif

//--- rtl/dl_pkg.sv
/*
 * Types for the ROM download path
 *   vector typedefs for download and memory widths
 *   host download bus and memory access structs
 *   cartridge loader FSM states and arbiter grant record
 */

`default_nettype none

`include "dl_macros.svh"

package dl_pkg;

	// Plain vectors
	typedef logic [15:0]            half_t;
	typedef logic [31:0]            word_t;
	typedef logic [26:0]            byte_addr_t;
	typedef logic [`DL_MEM_AW-1:0]  mem_addr_t;
	typedef logic [`DL_PIF_AW-1:0]  pif_addr_t;
	typedef logic [7:0]             dl_index_t;

	// Host download bus
	typedef struct packed {
		logic       download;
		logic       wr;
		dl_index_t  index;
		byte_addr_t addr;
		half_t      data;
	} ioctl_t;

	// One access to the shared word RAM
	typedef struct packed {
		logic      valid;
		logic      write;
		mem_addr_t addr;
		word_t     data;
	} mem_req_t;

	typedef enum logic [1:0] {
		CART_IDLE,
		CART_HAVE_LOW,
		CART_WRITE
	} cart_state_t;

	typedef enum logic {
		GRANT_CART,
		GRANT_CORE
	} grant_t;

endpackage

`default_nettype wire

//--- rtl/pifrom_loader.sv
/*
 * Boot-ROM loader
 *   packs two download halves into one byte-swapped word
 *   private boot-ROM RAM, upper half picked by index bit 6
 *   registered read port for the console side
 */

`timescale 1ns/1ps
`default_nettype none

`include "dl_macros.svh"

module pifrom_loader import dl_pkg::*; (
	input  logic      clk_1x,
	input  logic      rst,
	input  ioctl_t    ioctl,
	input  pif_addr_t pif_rd_addr,
	output word_t     pif_rd_data
);

	logic      pif_sel;
	logic      wr_en;
	pif_addr_t wr_addr;
	word_t     wr_data;
	word_t     rom [0:`DL_PIF_WORDS-1];

	assign pif_sel = ioctl.download && (ioctl.index[5:0] == `DL_IDX_PIF);

	// ==================================================
	// Word packing
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			wr_en <= 1'b0;
		end else begin
			wr_en <= pif_sel && ioctl.wr && ioctl.addr[1];
		end
	end

	// Bytes land swapped, low byte of each half first
	always_ff @(posedge clk_1x) begin
		if (pif_sel && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				wr_data[31:24] <= ioctl.data[7:0];
				wr_data[23:16] <= ioctl.data[15:8];
				wr_addr        <= pif_addr_t'({ioctl.index[6], ioctl.addr[10:2]});
			end else begin
				wr_data[15:8]  <= ioctl.data[7:0];
				wr_data[7:0]   <= ioctl.data[15:8];
			end
		end
	end

	// ==================================================
	// Boot-ROM RAM
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (wr_en) begin
			rom[wr_addr] <= wr_data;
		end
		pif_rd_data <= rom[pif_rd_addr];
	end

endmodule

`default_nettype wire

//--- rtl/cart_loader.sv
/*
 * Cartridge loader
 *   packs two download halves into one 32-bit word
 *   adds the main or transfer cartridge base to the word address
 *   holds the write request until accepted, with ioctl_wait as back-pressure
 *   sticky cart_loaded flag for the main cartridge
 */

`timescale 1ns/1ps
`default_nettype none

`include "dl_macros.svh"

module cart_loader import dl_pkg::*; (
	input  logic     clk_1x,
	input  logic     rst,
	input  ioctl_t   ioctl,
	output mem_req_t cart_req,
	input  logic     cart_ready,
	output logic     ioctl_wait,
	output logic     cart_loaded
);

	cart_state_t state;
	logic        n64_sel;
	logic        gb_sel;
	logic        cart_sel;
	logic        first_half;
	logic        second_half;
	mem_addr_t   base_sel;
	mem_addr_t   wr_addr;
	word_t       wr_data;

	assign n64_sel  = ioctl.download && (ioctl.index[5:0] == `DL_IDX_N64);
	assign gb_sel   = ioctl.download && (ioctl.index[5:0] == `DL_IDX_GB);
	assign cart_sel = n64_sel || gb_sel;

	assign first_half  = cart_sel && ioctl.wr && !ioctl.addr[1];
	assign second_half = cart_sel && ioctl.wr && ioctl.addr[1];

	assign base_sel = n64_sel ? mem_addr_t'(`DL_N64_BASE) : mem_addr_t'(`DL_GB_BASE);

	// ==================================================
	// FSM
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			state <= CART_IDLE;
		end else if (!cart_sel) begin
			state <= CART_IDLE;
		end else begin
			case (state)
				CART_IDLE: begin
					if (first_half) begin
						state <= CART_HAVE_LOW;
					end
				end
				CART_HAVE_LOW: begin
					if (second_half) begin
						state <= CART_WRITE;
					end
				end
				CART_WRITE: begin
					if (cart_ready) begin
						state <= CART_IDLE;
					end
				end
				default: state <= CART_IDLE;
			endcase
		end
	end

	// Payload, first half low and second half high
	always_ff @(posedge clk_1x) begin
		if (first_half && state != CART_WRITE) begin
			wr_data[15:0] <= ioctl.data;
			wr_addr       <= base_sel + ioctl.addr[`DL_MEM_AW+1:2];
		end
		if (second_half && state == CART_HAVE_LOW) begin
			wr_data[31:16] <= ioctl.data;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			cart_loaded <= 1'b0;
		end else if (n64_sel) begin
			cart_loaded <= 1'b1;
		end
	end

	assign cart_req = '{
		valid: (state == CART_WRITE),
		write: 1'b1,
		addr:  wr_addr,
		data:  wr_data
	};

	// Dropping download releases the host straight away
	assign ioctl_wait = (state == CART_WRITE) && ioctl.download;

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
/*
 * Round-robin arbiter for the shared word RAM
 *   cartridge writes against core reads, one grant per cycle
 *   side not granted last wins under contention
 *   cart_ready pulse and delayed core_rd_done
 */

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import dl_pkg::*; (
	input  logic      clk_1x,
	input  logic      rst,
	input  mem_req_t  cart_req,
	output logic      cart_ready,
	input  logic      core_rd_req,
	input  mem_addr_t core_rd_addr,
	output logic      core_rd_done,
	output mem_req_t  mem_req
);

	grant_t last_grant;
	logic   rd_issued;
	logic   cart_pend;
	logic   core_pend;
	logic   pick_cart;
	logic   pick_core;

	// Requests already granted stay masked until their owner drops them
	assign cart_pend = cart_req.valid && !cart_ready;
	assign core_pend = core_rd_req && !rd_issued && !core_rd_done;

	assign pick_core = core_pend && (!cart_pend || last_grant == GRANT_CART);
	assign pick_cart = cart_pend && !pick_core;

	// ==================================================
	// Grant record and handshakes
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			last_grant   <= GRANT_CORE;
			cart_ready   <= 1'b0;
			rd_issued    <= 1'b0;
			core_rd_done <= 1'b0;
		end else begin
			cart_ready   <= pick_cart;
			rd_issued    <= pick_core;
			// RAM data is valid one cycle after the access
			core_rd_done <= rd_issued;
			if (pick_cart) begin
				last_grant <= GRANT_CART;
			end else if (pick_core) begin
				last_grant <= GRANT_CORE;
			end
		end
	end

	// ==================================================
	// Access to the RAM
	// ==================================================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			mem_req.valid <= 1'b0;
			mem_req.write <= 1'b0;
		end else begin
			mem_req.valid <= pick_cart || pick_core;
			mem_req.write <= pick_cart;
		end
	end

	always_ff @(posedge clk_1x) begin
		mem_req.addr <= pick_cart ? cart_req.addr : core_rd_addr;
		mem_req.data <= cart_req.data;
	end

endmodule

`default_nettype wire

//--- rtl/word_ram.sv
/*
 * Shared word RAM
 *   write on valid write accesses
 *   read word registered on every valid access, old data on a write
 */

`timescale 1ns/1ps
`default_nettype none

`include "dl_macros.svh"

module word_ram import dl_pkg::*; (
	input  logic     clk_1x,
	input  mem_req_t mem_req,
	output word_t    rd_data
);

	word_t mem [0:`DL_MEM_WORDS-1];

	always_ff @(posedge clk_1x) begin
		if (mem_req.valid) begin
			if (mem_req.write) begin
				mem[mem_req.addr] <= mem_req.data;
			end
			// Read before write
			rd_data <= mem[mem_req.addr];
		end
	end

endmodule

`default_nettype wire

//--- rtl/download_top.sv
/*
 * ROM download top level
 *   boot-ROM loader with its own RAM
 *   cartridge loader and core read channel sharing one word RAM
 *   round-robin arbiter in front of that RAM
 */

`timescale 1ns/1ps
`default_nettype none

module download_top import dl_pkg::*; (
	input  logic      clk_1x,
	input  logic      rst,
	input  ioctl_t    ioctl,
	output logic      ioctl_wait,
	output logic      cart_loaded,
	input  logic      core_rd_req,
	input  mem_addr_t core_rd_addr,
	output logic      core_rd_done,
	output word_t     core_rd_data,
	input  pif_addr_t pif_rd_addr,
	output word_t     pif_rd_data
);

	mem_req_t cart_req;
	logic     cart_ready;
	mem_req_t mem_req;

	// ==================================================
	// Loaders
	// ==================================================
	pifrom_loader pifrom_loader0 (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.ioctl       (ioctl),
		.pif_rd_addr (pif_rd_addr),
		.pif_rd_data (pif_rd_data)
	);

	cart_loader cart_loader0 (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.ioctl       (ioctl),
		.cart_req    (cart_req),
		.cart_ready  (cart_ready),
		.ioctl_wait  (ioctl_wait),
		.cart_loaded (cart_loaded)
	);

	// ==================================================
	// Shared memory
	// ==================================================
	mem_arbiter mem_arbiter0 (
		.clk_1x       (clk_1x),
		.rst          (rst),
		.cart_req     (cart_req),
		.cart_ready   (cart_ready),
		.core_rd_req  (core_rd_req),
		.core_rd_addr (core_rd_addr),
		.core_rd_done (core_rd_done),
		.mem_req      (mem_req)
	);

	// Read data goes straight to the core side
	word_ram word_ram0 (
		.clk_1x  (clk_1x),
		.mem_req (mem_req),
		.rd_data (core_rd_data)
	);

endmodule

`default_nettype wire

//--- test/tb_download.sv
/*
 * Testbench for the ROM download top level
 *   table of download words applied in a loop
 *   reference copies of the shared RAM and the boot-ROM RAM
 *   contending core reads, xorshift data, watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "dl_macros.svh"

module tb_download import dl_pkg::*; ();

	localparam int N_TESTS        = 14;
	localparam int TIMEOUT_CYCLES = N_TESTS * 50 + 200;
	localparam logic [1:0] REG_PIF = 2'd0;
	localparam logic [1:0] REG_N64 = 2'd1;
	localparam logic [1:0] REG_GB  = 2'd2;

	// contend 0 none, 1 read with the second half, 2 read against the offered write
	typedef struct packed {
		dl_index_t  index;
		byte_addr_t addr;
		logic [1:0] contend;
		logic [1:0] region;
	} test_t;

	logic        clk_1x;
	logic        rst;
	ioctl_t      ioctl;
	logic        ioctl_wait;
	logic        cart_loaded;
	logic        core_rd_req;
	mem_addr_t   core_rd_addr;
	logic        core_rd_done;
	word_t       core_rd_data;
	pif_addr_t   pif_rd_addr;
	word_t       pif_rd_data;

	test_t       tests [N_TESTS];
	word_t       cart_mem [0:`DL_MEM_WORDS-1];
	word_t       pif_mem [0:`DL_PIF_WORDS-1];
	mem_addr_t   cart_addrs [$];
	pif_addr_t   pif_addrs [$];
	logic [31:0] rng;
	logic        last_cart;
	logic        loaded_exp;

	download_top dut0 (
		.clk_1x       (clk_1x),
		.rst          (rst),
		.ioctl        (ioctl),
		.ioctl_wait   (ioctl_wait),
		.cart_loaded  (cart_loaded),
		.core_rd_req  (core_rd_req),
		.core_rd_addr (core_rd_addr),
		.core_rd_done (core_rd_done),
		.core_rd_data (core_rd_data),
		.pif_rd_addr  (pif_rd_addr),
		.pif_rd_data  (pif_rd_data)
	);

	always #10 clk_1x = ~clk_1x;

	// ==================================================
	// Helpers
	// ==================================================
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic half_t next_half();
		rng = xorshift32(rng);
		return rng[15:0];
	endfunction

	task automatic core_read(input mem_addr_t addr, output word_t data);
		core_rd_addr = addr;
		core_rd_req  = 1'b1;
		@(negedge clk_1x);
		while (!core_rd_done) begin
			@(negedge clk_1x);
		end
		data        = core_rd_data;
		core_rd_req = 1'b0;
		last_cart   = 1'b0;
	endtask

	task automatic pif_read(input pif_addr_t addr, output word_t data);
		pif_rd_addr = addr;
		@(negedge clk_1x);
		data = pif_rd_data;
	endtask

	task automatic run_test(input test_t t);
		half_t     lo;
		half_t     hi;
		mem_addr_t waddr;
		pif_addr_t paddr;
		word_t     rd;
		word_t     exp_rd;
		lo     = next_half();
		hi     = next_half();
		waddr  = mem_addr_t'(((t.region == REG_N64) ? `DL_N64_BASE : `DL_GB_BASE)
			+ 32'(t.addr >> 2));
		paddr  = pif_addr_t'({t.index[6], t.addr[10:2]});
		exp_rd = {hi, lo};
		rd     = '0;
		ioctl.download = 1'b1;
		ioctl.index    = t.index;
		ioctl.wr       = 1'b1;
		ioctl.addr     = t.addr;
		ioctl.data     = lo;
		@(negedge clk_1x);
		ioctl.addr   = t.addr | 27'h2;
		ioctl.data   = hi;
		core_rd_addr = waddr;
		core_rd_req  = (t.contend == 2'd1);
		@(negedge clk_1x);
		ioctl.wr = 1'b0;
		check("ioctl_wait", 32'(ioctl_wait), 32'(t.region != REG_PIF));
		if (t.contend == 2'd2) begin
			core_rd_req = 1'b1;
		end
		// Core goes first when it asked early or the write was granted last
		if (t.contend == 2'd1 || (t.contend == 2'd2 && last_cart)) begin
			exp_rd    = cart_mem[waddr];
			last_cart = 1'b1;
		end else if (t.contend == 2'd2) begin
			last_cart = 1'b0;
		end else if (t.region != REG_PIF) begin
			last_cart = 1'b1;
		end
		while (ioctl_wait || core_rd_req) begin
			@(negedge clk_1x);
			if (core_rd_req && core_rd_done) begin
				rd          = core_rd_data;
				core_rd_req = 1'b0;
			end
		end
		if (t.region == REG_PIF) begin
			@(negedge clk_1x);
			ioctl.download = 1'b0;
			pif_mem[paddr] = {lo[7:0], lo[15:8], hi[7:0], hi[15:8]};
			pif_addrs.push_back(paddr);
			pif_read(paddr, rd);
			check("pif_rd_data", rd, pif_mem[paddr]);
		end else begin
			if (t.contend != 2'd0) begin
				check("core_rd_data (contended)", rd, exp_rd);
			end
			ioctl.download  = 1'b0;
			cart_mem[waddr] = {hi, lo};
			cart_addrs.push_back(waddr);
			loaded_exp = loaded_exp | (t.region == REG_N64);
			// After an early read the write stays granted last for the next overlap
			if (t.contend != 2'd1) begin
				core_read(waddr, rd);
				check("core_rd_data", rd, cart_mem[waddr]);
			end
			check("cart_loaded", 32'(cart_loaded), 32'(loaded_exp));
		end
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	initial begin
		int    i;
		word_t rd;
		clk_1x       = 1'b0;
		rst          = 1'b1;
		ioctl        = '0;
		core_rd_req  = 1'b0;
		core_rd_addr = '0;
		pif_rd_addr  = '0;
		rng          = 32'd79;
		last_cart    = 1'b0;
		loaded_exp   = 1'b0;
		tests[0]  = '{8'h02, 27'h000, 2'd0, REG_GB};
		tests[1]  = '{8'h02, 27'h004, 2'd0, REG_GB};
		tests[2]  = '{8'h00, 27'h000, 2'd0, REG_PIF};
		tests[3]  = '{8'h40, 27'h000, 2'd0, REG_PIF};
		tests[4]  = '{8'h00, 27'h7FC, 2'd0, REG_PIF};
		tests[5]  = '{8'h01, 27'h000, 2'd0, REG_N64};
		tests[6]  = '{8'h01, 27'h004, 2'd0, REG_N64};
		tests[7]  = '{8'h01, 27'h7FC, 2'd0, REG_N64};
		tests[8]  = '{8'h02, 27'h000, 2'd1, REG_GB};
		tests[9]  = '{8'h01, 27'h004, 2'd2, REG_N64};
		tests[10] = '{8'h02, 27'h004, 2'd2, REG_GB};
		tests[11] = '{8'h41, 27'h008, 2'd0, REG_N64};
		tests[12] = '{8'h01, 27'h000, 2'd1, REG_N64};
		tests[13] = '{8'h42, 27'h3FC, 2'd0, REG_GB};
		repeat (2) @(negedge clk_1x);
		rst = 1'b0;
		check("ioctl_wait", 32'(ioctl_wait), 32'd0);
		check("cart_loaded", 32'(cart_loaded), 32'd0);
		check("core_rd_done", 32'(core_rd_done), 32'd0);
		for (i = 0; i < N_TESTS; i++) begin
			run_test(tests[i]);
		end
		// Every region read back after all downloads
		foreach (cart_addrs[k]) begin
			core_read(cart_addrs[k], rd);
			check("core_rd_data (final)", rd, cart_mem[cart_addrs[k]]);
		end
		foreach (pif_addrs[k]) begin
			pif_read(pif_addrs[k], rd);
			check("pif_rd_data (final)", rd, pif_mem[pif_addrs[k]]);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_1x);
		$display("Timeout after %0d cycles, a download or read handshake never completed",
			TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/dl_pkg.sv
rtl/pifrom_loader.sv
rtl/cart_loader.sv
rtl/mem_arbiter.sv
rtl/word_ram.sv
rtl/download_top.sv
test/tb_download.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_download
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/dl_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
